// ==== all.f ====
+incdir+sim
rtl/rs_pkg.sv
rtl/rs_map_table.sv
rtl/rs_dispatch.sv
rtl/rs_entry.sv
rtl/rs_issue.sv
rtl/rs_top.sv
sim/tb_rs_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the reservation station testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_rs_top -f all.f

status=0
output="$(./obj_dir/Vtb_rs_top 2>&1)" || status=$?
echo "$output"

if grep -q "TB PASSED" <<< "$output"; then
   echo "simulation passed"
else
   echo "simulation failed with status ${status}"
   exit 1
fi

// ==== sim/tb_rs_util.svh ====
//////////////////////////////////////////////////
// testbench helpers for the reservation station
// random source, reference model of the operand
// rules and issue select, typed compare tasks
//////////////////////////////////////////////////

`ifndef TB_RS_UTIL_SVH
`define TB_RS_UTIL_SVH

// 16 bit galois lfsr, taps 16,14,13,11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per bit, msb first
function automatic logic [31:0] random_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
   end
   return r;
endfunction

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

// a waiting operand takes a matching broadcast and drops its tag
function automatic operand_t wake_operand(input operand_t op, input cdb_t c);
   operand_t r;
   r = op;
   if (c.valid && op.tag != 4'd0 && c.tag == op.tag) begin
      r.tag   = 4'd0;
      r.value = c.value;
   end
   return r;
endfunction

// empty or ready map entry means the supplied value is current
function automatic operand_t model_operand(
   input map_entry_t m,
   input word_t      supplied,
   input cdb_t       c
);
   operand_t pending;
   pending.tag   = m.tag;
   pending.value = '0;
   if (m.tag == 4'd0 || m.ready) begin
      pending.tag   = 4'd0;
      pending.value = supplied;
      return pending;
   end
   // same cycle broadcast counts too
   return wake_operand(pending, c);
endfunction

// locked choice first, else lowest ready station
function automatic logic expected_issue(
   input  station_t   st [unit_count],
   input  logic       locked,
   input  int         lock_idx,
   output int         sel,
   output issue_pkt_t pkt
);
   logic found;
   found = locked;
   sel   = lock_idx;
   for (int u = 0; u < unit_count; u++) begin
      if (!found && st[u].busy && st[u].op1.tag == 4'd0 && st[u].op2.tag == 4'd0) begin
         found = 1'b1;
         sel   = u;
      end
   end
   pkt.unit      = st[sel].unit;
   pkt.dest_tag  = st[sel].dest_tag;
   pkt.op1_value = st[sel].op1.value;
   pkt.op2_value = st[sel].op2.value;
   return found;
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_issue(input string name, input issue_pkt_t exp, input issue_pkt_t act);
   if (act !== exp) begin
      fail_run($sformatf("mismatch %s issue_pkt expected %h actual %h", name, exp, act));
   end
endtask

task automatic check_ready(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      fail_run($sformatf("mismatch %s dispatch_ready expected %b actual %b", name, exp, act));
   end
endtask

task automatic check_valid(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      fail_run($sformatf("mismatch %s issue_valid expected %b actual %b", name, exp, act));
   end
endtask

`endif

// ==== sim/tb_rs_top.sv ====
//////////////////////////////////////////////////
// reservation station testbench
// directed tests of reset, wakeup, rename, retire
// and back-pressure, then a random run against
// a reference model checked every cycle
//////////////////////////////////////////////////

module tb_rs_top;

   timeunit 1ns;
   timeprecision 100ps;

   import rs_pkg::*;

   // stimulus length sets the timeout
   localparam int directed_cycles = 50;
   localparam int random_cycles   = 2000;
   localparam int timeout_cycles  = 2 * (directed_cycles + random_cycles) + 100;

   logic          clock;
   logic          reset;
   logic          dispatch_valid;
   dispatch_req_t dispatch_req;
   logic          dispatch_ready;
   cdb_t          cdb;
   retire_t       retire;
   logic          issue_valid;
   issue_pkt_t    issue_pkt;
   logic          issue_ready;

   logic [15:0] lfsr_state = 16'd54480;
   string       test_name  = "reset";
   int          cycle_count = 0;

   // scoreboard state
   map_entry_t m_map [reg_count];
   station_t   m_st [unit_count];
   logic       m_locked;
   int         m_lock_idx;

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   `include "tb_rs_util.svh"

   rs_top dut (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch_req   (dispatch_req),
      .dispatch_ready (dispatch_ready),
      .cdb            (cdb),
      .retire         (retire),
      .issue_valid    (issue_valid),
      .issue_pkt      (issue_pkt),
      .issue_ready    (issue_ready)
   );

   always #2 clock = ~clock;

   //////////////////////////////////////////////////
   // scoreboard update at each edge
   //////////////////////////////////////////////////

   always @(posedge clock) begin
      issue_pkt_t pkt;
      station_t   ns;
      logic       pres;
      logic       take;
      int         sel;
      if (reset) begin
         for (int i = 0; i < reg_count; i++) begin
            m_map[i] = '0;
         end
         for (int u = 0; u < unit_count; u++) begin
            m_st[u] = '0;
         end
         m_locked   = 1'b0;
         m_lock_idx = 0;
      end else begin
         pres = expected_issue(m_st, m_locked, m_lock_idx, sel, pkt);
         take = dispatch_valid && !m_st[dispatch_req.unit].busy;
         // operands from the map as it was before this edge
         ns.busy     = 1'b1;
         ns.unit     = dispatch_req.unit;
         ns.dest_tag = dispatch_req.tag;
         ns.op1 = model_operand(m_map[dispatch_req.src1_reg], dispatch_req.src1_value, cdb);
         ns.op2 = model_operand(m_map[dispatch_req.src2_reg], dispatch_req.src2_value, cdb);
         // rename over retire over cdb, r0 never renamed
         for (int i = 1; i < reg_count; i++) begin
            if (take && dispatch_req.dest_reg == reg_idx_t'(i)) begin
               m_map[i] = '{tag: dispatch_req.tag, ready: 1'b0};
            end else if (retire.valid && retire.dest_reg == reg_idx_t'(i) &&
                         retire.tag == m_map[i].tag) begin
               m_map[i] = '0;
            end else if (cdb.valid && m_map[i].tag != 4'd0 && cdb.tag == m_map[i].tag) begin
               m_map[i].ready = 1'b1;
            end
         end
         for (int u = 0; u < unit_count; u++) begin
            if (take && int'(dispatch_req.unit) == u) begin
               m_st[u] = ns;
            end else begin
               if (pres && issue_ready && sel == u) begin
                  m_st[u].busy = 1'b0;
               end
               m_st[u].op1 = wake_operand(m_st[u].op1, cdb);
               m_st[u].op2 = wake_operand(m_st[u].op2, cdb);
            end
         end
         // presented and not taken stays chosen
         m_locked = pres && !issue_ready;
         if (m_locked) begin
            m_lock_idx = sel;
         end
      end
   end

   //////////////////////////////////////////////////
   // checker, mid cycle while outputs are stable
   //////////////////////////////////////////////////

   always @(negedge clock) begin
      issue_pkt_t exp_pkt;
      logic       exp_valid;
      int         sel;
      if (!reset) begin
         exp_valid = expected_issue(m_st, m_locked, m_lock_idx, sel, exp_pkt);
         check_valid(test_name, exp_valid, issue_valid);
         check_ready(test_name, !m_st[dispatch_req.unit].busy, dispatch_ready);
         if (exp_valid) begin
            check_issue(test_name, exp_pkt, issue_pkt);
         end
      end
   end

   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
         fail_run("timeout, the run did not finish within the cycle limit");
      end
   end

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////

   // strobes last one cycle
   task automatic next_cycle();
      @(posedge clock);
      #1;
      dispatch_valid = 1'b0;
      cdb            = '0;
      retire         = '0;
   endtask

   task automatic dispatch_instr(
      input unit_e    u,
      input reg_idx_t d,
      input reg_idx_t s1,
      input reg_idx_t s2,
      input word_t    v1,
      input word_t    v2,
      input rob_tag_t t
   );
      dispatch_valid          = 1'b1;
      dispatch_req.unit       = u;
      dispatch_req.dest_reg   = d;
      dispatch_req.src1_reg   = s1;
      dispatch_req.src2_reg   = s2;
      dispatch_req.src1_value = v1;
      dispatch_req.src2_value = v2;
      dispatch_req.tag        = t;
   endtask

   task automatic broadcast_cdb(input rob_tag_t t, input word_t v);
      cdb = '{valid: 1'b1, tag: t, value: v};
   endtask

   task automatic retire_instr(input reg_idx_t r, input rob_tag_t t);
      retire = '{valid: 1'b1, dest_reg: r, tag: t};
   endtask

   // expected packet written out from the test itself
   task automatic expect_issue(
      input unit_e    u,
      input rob_tag_t t,
      input word_t    v1,
      input word_t    v2
   );
      issue_pkt_t exp;
      exp.unit      = u;
      exp.dest_tag  = t;
      exp.op1_value = v1;
      exp.op2_value = v2;
      @(negedge clock);
      check_valid(test_name, 1'b1, issue_valid);
      check_issue(test_name, exp, issue_pkt);
   endtask

   task automatic expect_idle();
      @(negedge clock);
      check_valid(test_name, 1'b0, issue_valid);
   endtask

   function automatic reg_idx_t random_reg();
      logic [31:0] r;
      r = random_bits(5);
      return r[4:0];
   endfunction

   // tags 1 to 15 only
   function automatic rob_tag_t random_tag();
      logic [31:0] r;
      r = random_bits(4);
      return (r[3:0] == 4'd0) ? 4'd1 : r[3:0];
   endfunction

   task automatic random_cycle();
      logic [31:0] r;
      issue_ready = random_bits(2) != 32'd0;
      r = random_bits(1);
      dispatch_valid = r[0];
      r = random_bits(2);
      dispatch_req.unit       = unit_e'(r[1:0]);
      dispatch_req.dest_reg   = random_reg();
      dispatch_req.src1_reg   = random_reg();
      dispatch_req.src2_reg   = random_reg();
      dispatch_req.src1_value = random_bits(32);
      dispatch_req.src2_value = random_bits(32);
      dispatch_req.tag        = random_tag();
      r = random_bits(1);
      cdb.valid = r[0];
      cdb.tag   = random_tag();
      cdb.value = random_bits(32);
      // retire about one cycle in four
      retire.valid    = random_bits(2) == 32'd0;
      retire.dest_reg = random_reg();
      retire.tag      = random_tag();
      next_cycle();
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      clock          = 1'b0;
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      dispatch_req   = '0;
      cdb            = '0;
      retire         = '0;
      issue_ready    = 1'b0;
      repeat (2) @(posedge clock);
      #1;
      reset = 1'b0;

      // every class free after reset
      test_name = "reset state";
      for (int u = 0; u < unit_count; u++) begin
         dispatch_req.unit = unit_e'(u);
         expect_idle();
         check_ready(test_name, 1'b1, dispatch_ready);
         next_cycle();
      end

      test_name = "ready operands";
      issue_ready = 1'b1;
      dispatch_instr(unit_alu, 5'd5, 5'd1, 5'd2, 32'h11, 32'h22, 4'd1);
      next_cycle();
      // station still busy this cycle, second alu refused
      dispatch_instr(unit_alu, 5'd6, 5'd3, 5'd4, 32'h33, 32'h44, 4'd2);
      expect_issue(unit_alu, 4'd1, 32'h11, 32'h22);
      check_ready(test_name, 1'b0, dispatch_ready);
      next_cycle();
      dispatch_instr(unit_alu, 5'd6, 5'd3, 5'd4, 32'h33, 32'h44, 4'd2);
      expect_idle();
      check_ready(test_name, 1'b1, dispatch_ready);
      next_cycle();
      expect_issue(unit_alu, 4'd2, 32'h33, 32'h44);
      next_cycle();

      test_name = "rename and wakeup";
      dispatch_instr(unit_mem, 5'd7, 5'd0, 5'd0, 32'h70, 32'h71, 4'd3);
      next_cycle();
      // consumer of r7 waits on tag 3
      dispatch_instr(unit_branch, 5'd8, 5'd7, 5'd0, 32'h33, 32'h44, 4'd4);
      expect_issue(unit_mem, 4'd3, 32'h70, 32'h71);
      next_cycle();
      expect_idle();
      next_cycle();
      broadcast_cdb(4'd3, 32'hAAAA);
      expect_idle();
      next_cycle();
      expect_issue(unit_branch, 4'd4, 32'hAAAA, 32'h44);
      next_cycle();
      dispatch_instr(unit_mul, 5'd9, 5'd0, 5'd0, 32'h90, 32'h91, 4'd5);
      next_cycle();
      // broadcast lands in the dispatch cycle
      dispatch_instr(unit_alu, 5'd10, 5'd9, 5'd9, 32'h1, 32'h2, 4'd6);
      broadcast_cdb(4'd5, 32'hBBBB);
      expect_issue(unit_mul, 4'd5, 32'h90, 32'h91);
      next_cycle();
      expect_issue(unit_alu, 4'd6, 32'hBBBB, 32'hBBBB);
      next_cycle();

      test_name = "retire and ready bit";
      // r7 ready since tag 3 broadcast
      dispatch_instr(unit_mem, 5'd11, 5'd7, 5'd0, 32'h55, 32'h56, 4'd7);
      next_cycle();
      // stale tag, r10 keeps waiting on tag 6
      retire_instr(5'd10, 4'd2);
      expect_issue(unit_mem, 4'd7, 32'h55, 32'h56);
      next_cycle();
      dispatch_instr(unit_branch, 5'd12, 5'd10, 5'd0, 32'h66, 32'h67, 4'd8);
      next_cycle();
      retire_instr(5'd10, 4'd6);
      expect_idle();
      next_cycle();
      // r10 cleared, supplied value used
      dispatch_instr(unit_mul, 5'd13, 5'd10, 5'd0, 32'h77, 32'h78, 4'd9);
      expect_idle();
      next_cycle();
      broadcast_cdb(4'd6, 32'hCCCC);
      expect_issue(unit_mul, 4'd9, 32'h77, 32'h78);
      next_cycle();
      expect_issue(unit_branch, 4'd8, 32'hCCCC, 32'h67);
      next_cycle();

      test_name = "back-pressure";
      issue_ready = 1'b0;
      dispatch_instr(unit_mul, 5'd14, 5'd0, 5'd0, 32'hA0, 32'hA1, 4'd10);
      next_cycle();
      dispatch_instr(unit_branch, 5'd15, 5'd0, 5'd0, 32'hB0, 32'hB1, 4'd11);
      expect_issue(unit_mul, 4'd10, 32'hA0, 32'hA1);
      next_cycle();
      dispatch_instr(unit_mem, 5'd16, 5'd0, 5'd0, 32'hC0, 32'hC1, 4'd12);
      expect_issue(unit_mul, 4'd10, 32'hA0, 32'hA1);
      next_cycle();
      dispatch_instr(unit_alu, 5'd17, 5'd0, 5'd0, 32'hD0, 32'hD1, 4'd13);
      expect_issue(unit_mul, 4'd10, 32'hA0, 32'hA1);
      next_cycle();
      // locked mul first, then alu, mem, branch
      issue_ready = 1'b1;
      expect_issue(unit_mul, 4'd10, 32'hA0, 32'hA1);
      next_cycle();
      expect_issue(unit_alu, 4'd13, 32'hD0, 32'hD1);
      next_cycle();
      expect_issue(unit_mem, 4'd12, 32'hC0, 32'hC1);
      next_cycle();
      expect_issue(unit_branch, 4'd11, 32'hB0, 32'hB1);
      next_cycle();
      expect_idle();
      next_cycle();

      test_name = "random";
      repeat (random_cycles) begin
         random_cycle();
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== rtl/rs_top.sv ====
//////////////////////////////////////////////////
// reservation station top
// map table, dispatch, one entry per unit class
// and the shared issue port
//////////////////////////////////////////////////

module rs_top (
   input  logic                   clock,
   input  logic                   reset,
   // dispatch side
   input  logic                   dispatch_valid,
   input  rs_pkg::dispatch_req_t  dispatch_req,
   output logic                   dispatch_ready,
   // broadcasts
   input  rs_pkg::cdb_t           cdb,
   input  rs_pkg::retire_t        retire,
   // execution side
   output logic                   issue_valid,
   output rs_pkg::issue_pkt_t     issue_pkt,
   input  logic                   issue_ready
);

   import rs_pkg::*;

   map_entry_t src1_map;
   map_entry_t src2_map;
   logic       rename_valid;
   reg_idx_t   rename_reg;
   rob_tag_t   rename_tag;
   unit_mask_t load;
   unit_mask_t clear;
   unit_mask_t entry_ready;
   unit_mask_t station_busy;
   station_t   new_station;
   station_t   stations [unit_count];

   rs_map_table u_map_table (
      .clock        (clock),
      .reset        (reset),
      .src1_reg     (dispatch_req.src1_reg),
      .src2_reg     (dispatch_req.src2_reg),
      .rename_valid (rename_valid),
      .rename_reg   (rename_reg),
      .rename_tag   (rename_tag),
      .cdb          (cdb),
      .retire       (retire),
      .src1_map     (src1_map),
      .src2_map     (src2_map)
   );

   rs_dispatch u_dispatch (
      .req            (dispatch_req),
      .dispatch_valid (dispatch_valid),
      .dispatch_ready (dispatch_ready),
      .station_busy   (station_busy),
      .src1_map       (src1_map),
      .src2_map       (src2_map),
      .cdb            (cdb),
      .rename_valid   (rename_valid),
      .rename_reg     (rename_reg),
      .rename_tag     (rename_tag),
      .load           (load),
      .new_station    (new_station)
   );

   //////////////////////////////////////////////////
   // stations, index equals unit class
   //////////////////////////////////////////////////

   for (genvar i = 0; i < unit_count; i++) begin : g_entry
      rs_entry u_entry (
         .clock       (clock),
         .reset       (reset),
         .load        (load[i]),
         .new_station (new_station),
         .cdb         (cdb),
         .clear       (clear[i]),
         .station     (stations[i]),
         .ready       (entry_ready[i])
      );
      assign station_busy[i] = stations[i].busy;
   end

   rs_issue u_issue (
      .clock       (clock),
      .reset       (reset),
      .stations    (stations),
      .entry_ready (entry_ready),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt),
      .issue_ready (issue_ready),
      .clear       (clear)
   );

endmodule

// ==== rtl/rs_issue.sv ====
//////////////////////////////////////////////////
// issue select
// fixed priority pick among ready stations with a
// lock that holds the choice under back-pressure
//////////////////////////////////////////////////

module rs_issue (
   input  logic                clock,
   input  logic                reset,
   input  rs_pkg::station_t    stations [rs_pkg::unit_count],
   input  rs_pkg::unit_mask_t  entry_ready,
   output logic                issue_valid,
   output rs_pkg::issue_pkt_t  issue_pkt,
   input  logic                issue_ready,
   // one strobe per station, frees it on the transfer
   output rs_pkg::unit_mask_t  clear
);

   import rs_pkg::*;

   logic  any_ready;
   unit_e pick_idx;
   unit_e sel_idx;
   // held choice while execution side stalls
   logic  locked_q;
   unit_e lock_idx_q;

   //////////////////////////////////////////////////
   // selection
   //////////////////////////////////////////////////

   // lowest index wins: alu, mem, branch, mul
   always_comb begin
      any_ready = 1'b0;
      pick_idx  = unit_alu;
      for (int i = unit_count - 1; i >= 0; i--) begin
         if (entry_ready[i]) begin
            any_ready = 1'b1;
            pick_idx  = unit_e'(i);
         end
      end
   end

   // locked entry stays ready, its tags are already zero
   assign sel_idx     = locked_q ? lock_idx_q : pick_idx;
   assign issue_valid = locked_q || any_ready;

   assign issue_pkt.unit      = stations[sel_idx].unit;
   assign issue_pkt.dest_tag  = stations[sel_idx].dest_tag;
   assign issue_pkt.op1_value = stations[sel_idx].op1.value;
   assign issue_pkt.op2_value = stations[sel_idx].op2.value;

   always_comb begin
      clear = '0;
      if (issue_valid && issue_ready) begin
         clear[sel_idx] = 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // lock
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         locked_q <= 1'b0;
      end else begin
         // presented but not taken, keep it
         locked_q <= issue_valid && !issue_ready;
      end
   end

   // captures the presented station on a stall
   always_ff @(posedge clock) begin
      if (issue_valid && !issue_ready) begin
         lock_idx_q <= sel_idx;
      end
   end

endmodule

// ==== rtl/rs_entry.sv ====
//////////////////////////////////////////////////
// reservation station entry
// holds one instruction's operands and tags,
// captures cdb values and reports readiness
//////////////////////////////////////////////////

module rs_entry (
   input  logic              clock,
   input  logic              reset,
   // from dispatch
   input  logic              load,
   input  rs_pkg::station_t  new_station,
   input  rs_pkg::cdb_t      cdb,
   // from issue, station leaves on this edge
   input  logic              clear,
   output rs_pkg::station_t  station,
   output logic              ready
);

   import rs_pkg::*;

   station_t station_q;

   // cdb hits per operand, only while waiting
   logic op1_hit;
   logic op2_hit;

   assign op1_hit = cdb.valid && (station_q.op1.tag != '0) &&
                    (station_q.op1.tag == cdb.tag);
   assign op2_hit = cdb.valid && (station_q.op2.tag != '0) &&
                    (station_q.op2.tag == cdb.tag);

   //////////////////////////////////////////////////
   // station register
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         // station free after reset
         station_q.busy <= 1'b0;
      end else if (load) begin
         // dispatch already folded in a same cycle cdb
         station_q <= new_station;
      end else begin
         if (clear) begin
            station_q.busy <= 1'b0;
         end
         // wakeup, both operands may match the same tag
         if (op1_hit) begin
            station_q.op1.tag   <= '0;
            station_q.op1.value <= cdb.value;
         end
         if (op2_hit) begin
            station_q.op2.tag   <= '0;
            station_q.op2.value <= cdb.value;
         end
      end
   end

   //////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////

   assign station = station_q;

   // from registered state only
   // a cdb this edge shows up next cycle
   assign ready = station_q.busy &&
                  (station_q.op1.tag == '0) &&
                  (station_q.op2.tag == '0);

endmodule

// ==== rtl/rs_dispatch.sv ====
//////////////////////////////////////////////////
// dispatch
// looks up source operands, builds the new station
// and routes it to the station of its unit class
//////////////////////////////////////////////////

module rs_dispatch (
   input  rs_pkg::dispatch_req_t  req,
   input  logic                   dispatch_valid,
   output logic                   dispatch_ready,
   // registered busy bits of the stations
   input  rs_pkg::unit_mask_t     station_busy,
   input  rs_pkg::map_entry_t     src1_map,
   input  rs_pkg::map_entry_t     src2_map,
   input  rs_pkg::cdb_t           cdb,
   // rename write to the map table
   output logic                   rename_valid,
   output rs_pkg::reg_idx_t       rename_reg,
   output rs_pkg::rob_tag_t       rename_tag,
   output rs_pkg::unit_mask_t     load,
   output rs_pkg::station_t       new_station
);

   import rs_pkg::*;

   logic transfer;

   //////////////////////////////////////////////////
   // operand rule
   //////////////////////////////////////////////////

   // empty or ready entry takes the supplied value,
   // a waiting entry may still catch the cdb this cycle
   function automatic operand_t build_operand(
      input map_entry_t m,
      input word_t      supplied,
      input cdb_t       c
   );
      operand_t op;
      if ((m.tag == '0) || m.ready) begin
         op.tag   = '0;
         op.value = supplied;
      end else if (c.valid && (c.tag == m.tag)) begin
         op.tag   = '0;
         op.value = c.value;
      end else begin
         // value filled later by wakeup
         op.tag   = m.tag;
         op.value = '0;
      end
      return op;
   endfunction

   //////////////////////////////////////////////////
   // handshake and routing
   //////////////////////////////////////////////////

   // target station index is the unit class itself
   assign dispatch_ready = !station_busy[req.unit];
   assign transfer       = dispatch_valid && dispatch_ready;

   always_comb begin
      load = '0;
      if (transfer) begin
         load[req.unit] = 1'b1;
      end
   end

   // new producer of the destination register
   assign rename_valid = transfer;
   assign rename_reg   = req.dest_reg;
   assign rename_tag   = req.tag;

   // shared by all stations, only the loaded one takes it
   always_comb begin
      new_station.busy     = 1'b1;
      new_station.unit     = req.unit;
      new_station.dest_tag = req.tag;
      new_station.op1      = build_operand(src1_map, req.src1_value, cdb);
      new_station.op2      = build_operand(src2_map, req.src2_value, cdb);
   end

endmodule

// ==== rtl/rs_map_table.sv ====
//////////////////////////////////////////////////
// rename map table
// newest producer tag and ready bit for every
// architectural register, updated by rename,
// retire and cdb broadcasts
//////////////////////////////////////////////////

module rs_map_table (
   input  logic                clock,
   input  logic                reset,
   // source lookups for dispatch
   input  rs_pkg::reg_idx_t    src1_reg,
   input  rs_pkg::reg_idx_t    src2_reg,
   // rename write from dispatch
   input  logic                rename_valid,
   input  rs_pkg::reg_idx_t    rename_reg,
   input  rs_pkg::rob_tag_t    rename_tag,
   input  rs_pkg::cdb_t        cdb,
   input  rs_pkg::retire_t     retire,
   output rs_pkg::map_entry_t  src1_map,
   output rs_pkg::map_entry_t  src2_map
);

   import rs_pkg::*;

   // one entry per register, entry 0 stays empty
   map_entry_t table_q [reg_count];

   //////////////////////////////////////////////////
   // update
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < reg_count; i++) begin
            table_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < reg_count; i++) begin
            // rename wins over everything, never for r0
            if (rename_valid && (rename_reg == reg_idx_t'(i)) && (i != 0)) begin
               table_q[i].tag   <= rename_tag;
               table_q[i].ready <= 1'b0;
            end else if (retire.valid && (retire.dest_reg == reg_idx_t'(i)) &&
                         (retire.tag == table_q[i].tag)) begin
               // retiring tag still newest, value now in regfile
               table_q[i] <= '0;
            end else if (cdb.valid && (table_q[i].tag != '0) &&
                         (cdb.tag == table_q[i].tag)) begin
               // result broadcast, consumers read it from the rob
               table_q[i].ready <= 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // lookup
   //////////////////////////////////////////////////

   // plain read of registered state
   assign src1_map = table_q[src1_reg];
   assign src2_map = table_q[src2_reg];

endmodule

// ==== rtl/rs_pkg.sv ====
//////////////////////////////////////////////////
// reservation station package
// widths, unit classes, typedefs and the packed
// structs shared by map table, dispatch, entries
// and issue
//////////////////////////////////////////////////

package rs_pkg;

   //////////////////////////////////////////////////
   // widths and counts
   //////////////////////////////////////////////////

   // operand width
   localparam int xlen       = 32;
   // rob tag width, tag 0 means no producer
   localparam int tag_bits   = 4;
   // architectural registers
   localparam int reg_count  = 32;
   localparam int reg_bits   = $clog2(reg_count);
   // one station per unit class
   localparam int unit_count = 4;

   //////////////////////////////////////////////////
   // plain vector types
   //////////////////////////////////////////////////

   typedef logic [xlen-1:0]       word_t;
   typedef logic [tag_bits-1:0]   rob_tag_t;
   typedef logic [reg_bits-1:0]   reg_idx_t;
   // one bit per station
   typedef logic [unit_count-1:0] unit_mask_t;

   // value doubles as the station index
   typedef enum logic [1:0] {
      unit_alu    = 2'd0,
      unit_mem    = 2'd1,
      unit_branch = 2'd2,
      unit_mul    = 2'd3
   } unit_e;

   //////////////////////////////////////////////////
   // structs
   //////////////////////////////////////////////////

   // newest producer of a register, ready once seen on the cdb
   typedef struct packed {
      rob_tag_t tag;
      logic     ready;
   } map_entry_t;

   // renamed instruction from the front end
   typedef struct packed {
      unit_e    unit;
      reg_idx_t dest_reg;
      reg_idx_t src1_reg;
      reg_idx_t src2_reg;
      // values from register file or rob
      word_t    src1_value;
      word_t    src2_value;
      rob_tag_t tag;
   } dispatch_req_t;

   // common data bus broadcast
   typedef struct packed {
      logic     valid;
      rob_tag_t tag;
      word_t    value;
   } cdb_t;

   // retiring instruction
   typedef struct packed {
      logic     valid;
      reg_idx_t dest_reg;
      rob_tag_t tag;
   } retire_t;

   // tag nonzero while still waiting on the cdb
   typedef struct packed {
      rob_tag_t tag;
      word_t    value;
   } operand_t;

   typedef struct packed {
      logic     busy;
      unit_e    unit;
      rob_tag_t dest_tag;
      operand_t op1;
      operand_t op2;
   } station_t;

   // what the execution units see
   typedef struct packed {
      unit_e    unit;
      rob_tag_t dest_tag;
      word_t    op1_value;
      word_t    op2_value;
   } issue_pkt_t;

endpackage
